// File: Bender.yml
package:
  name: gpio_readback

sources:
  - source/readback_pkg.sv
  - source/uptime_clock.sv
  - source/system_state_tracker.sv
  - source/readback_mux.sv
  - source/gpio_readback_top.sv

  - target: simulation
    files:
      - bench/readback_tb.sv

// File: compile.f
source/readback_pkg.sv
source/uptime_clock.sv
source/system_state_tracker.sv
source/readback_mux.sv
source/gpio_readback_top.sv
bench/readback_tb.sv

// File: bench/readback_tb.sv
`timescale 1ns/1ps

// Directed testbench for the GPIO readback path
module readback_tb
    import readback_pkg::*;
();

    localparam int unsigned tb_ticks = 20;   // Short second
    localparam int          max_cycles = 2000;

    logic         aclk;
    logic         reset;
    logic [31:0]  config_addr;
    rb_monitors_t monitors;
    logic [31:0]  gpio_a;
    logic [31:0]  gpio_b;
    logic [31:0]  clock_sec;
    logic [31:0]  clock_ticks;

    int       errors = 0;
    int       checks = 0;
    int       cycles = 0;
    rb_pair_t pairs [9];     // Expected monitor values, z first

    gpio_readback_top #(
        .ticks_per_second(tb_ticks)
    ) DUT (
        .aclk       (aclk),
        .reset      (reset),
        .config_addr(config_addr),
        .monitors   (monitors),
        .gpio_a     (gpio_a),
        .gpio_b     (gpio_b),
        .clock_sec  (clock_sec),
        .clock_ticks(clock_ticks)
    );

    always #4 aclk = ~aclk; // 8 ns period

    // Run limit
    always @(posedge aclk)
    begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles)
        begin
            $display("Timeout: run did not finish within %0d cycles", max_cycles);
            $display("Simulation FAILED");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////
    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp)
        begin
            $display("Fail at %0t ns: %s = %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic drive_addr(input logic [31:0] addr);
        @(posedge aclk);
        config_addr <= addr; // Seen by the DUT at the next edge
    endtask

    // One edge, then sample mid-cycle
    task automatic next_sample;
        @(posedge aclk);
        @(negedge aclk);
    endtask

    ////////////////////////////////////////////////////////////
    // Tests
    ////////////////////////////////////////////////////////////
    task automatic cold_start_flow;
        logic [31:0] count;
        count = 0;
        drive_addr(rb_addr_system_state);
        next_sample;
        check("state_count after reset", gpio_a, 32'd0);
        check("startup after reset", gpio_b, 32'd1);
        drive_addr(rb_addr_version); // Ends cold start
        next_sample;
        drive_addr(rb_addr_system_state);
        next_sample;
        check("startup after version read", gpio_b, 32'd0);
        check("state_count without arming", gpio_a, count);
        repeat (2)
        begin
            drive_addr(32'h0000_0042); // Unmapped, arms tracker
            next_sample;
            drive_addr(rb_addr_system_state);
            next_sample;
            check("state_count on armed read", gpio_a, count); // Old value
            repeat (3) next_sample;
            count++;
            check("state_count after armed read", gpio_a, count);
        end
        // Mapped address in between does not rearm
        drive_addr(rb_addr_timing_reset);
        next_sample;
        drive_addr(rb_addr_system_state);
        repeat (4) next_sample;
        check("state_count on repeated read", gpio_a, count);
    endtask

    task automatic monitor_pairs;
        logic [31:0] addrs [9];
        addrs = '{rb_addr_z, rb_addr_bias, rb_addr_gvp_bias, rb_addr_pmd_da56,
                  rb_addr_z_servo, rb_addr_amc_fmc, rb_addr_srcs_mux, rb_addr_ad463x,
                  rb_addr_spare};
        for (int i = 0; i < 9; i++)
        begin
            for (int k = 0; k < 9; k++)
            begin
                pairs[k].a = $urandom;
                pairs[k].b = $urandom;
            end
            @(posedge aclk);
            monitors    <= {pairs[0], pairs[1], pairs[2], pairs[3], pairs[4],
                            pairs[5], pairs[6], pairs[7], pairs[8]};
            config_addr <= addrs[i];
            next_sample;
            check($sformatf("gpio_a monitor %0d", i), gpio_a, pairs[i].a);
            check($sformatf("gpio_b monitor %0d", i), gpio_b, pairs[i].b);
        end
        drive_addr(rb_addr_in_mux);
        next_sample;
        check("gpio_a input mux", gpio_a, pairs[6].b); // Input selection
        check("gpio_b input mux", gpio_b, 32'd0);
    endtask

    task automatic fixed_words;
        drive_addr(rb_addr_version);
        next_sample;
        check("gpio_a version", gpio_a, fw_version);
        check("gpio_b build date", gpio_b, fw_build_date);
        drive_addr(rb_addr_timing_reset);
        next_sample;
        check("gpio_a timing reset", gpio_a, 32'd0);
        check("gpio_b timing reset", gpio_b, 32'd0);
        drive_addr(rb_addr_timing_test);
        next_sample;
        check("gpio_b timing test first", gpio_b, 32'd0); // Old A from timing reset
        next_sample; // B now trails a constant A
        check("gpio_a timing test", gpio_a, timing_test_word);
        check("gpio_b timing test", gpio_b, timing_test_word);
    endtask

    task automatic pattern_sequence;
        logic [31:0] prev_a;
        drive_addr(32'h00AB_CDEF);
        next_sample;
        prev_a = gpio_a;
        repeat (6)
        begin
            next_sample;
            check("gpio_a pattern", gpio_a, prev_a + 32'd1);
            check("gpio_b pattern", gpio_b, prev_a + 32'd13);
            prev_a = prev_a + 32'd1;
        end
    endtask

    task automatic uptime_count;
        logic [31:0] sec0;
        logic [31:0] tick0;
        logic [31:0] csec0;
        logic [31:0] ctick0;
        drive_addr(rb_addr_uptime);
        next_sample;
        sec0   = gpio_a;
        tick0  = gpio_b;
        csec0  = clock_sec;   // Direct outputs, one update ahead
        ctick0 = clock_ticks;
        repeat (tb_ticks)
        begin
            next_sample;
            check("gpio_b ticks below 20", {31'd0, gpio_b < tb_ticks}, 32'd1);
            check("clock_ticks below 20", {31'd0, clock_ticks < tb_ticks}, 32'd1);
        end
        check("gpio_a seconds after one second", gpio_a, sec0 + 32'd1);
        check("gpio_b ticks after one second", gpio_b, tick0);
        check("clock_sec after one second", clock_sec, csec0 + 32'd1);
        check("clock_ticks after one second", clock_ticks, ctick0);
    endtask

    task automatic mid_run_reset;
        drive_addr(32'h0000_7777); // Pattern running
        repeat (3) next_sample;
        @(posedge aclk);
        reset       <= 1'b1;
        config_addr <= rb_addr_timing_reset;
        next_sample; // First edge with reset seen
        check("gpio_a in reset", gpio_a, 32'd0);
        check("gpio_b in reset", gpio_b, 32'd0);
        check("clock_sec in reset", clock_sec, 32'd0);
        check("clock_ticks in reset", clock_ticks, 32'd0);
        repeat (4) @(posedge aclk);
        reset <= 1'b0;
        drive_addr(rb_addr_system_state);
        next_sample;
        check("state_count after reset", gpio_a, 32'd0);
        check("startup after reset", gpio_b, 32'd1);
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////
    initial
    begin
        aclk        = 1'b0;
        reset       = 1'b1;
        config_addr = rb_addr_timing_reset;
        monitors    = '0;
        void'($urandom(32'h6f8104e3));

        repeat (5) @(posedge aclk);
        reset <= 1'b0;

        cold_start_flow;    // Needs fresh reset
        monitor_pairs;
        fixed_words;
        pattern_sequence;
        uptime_count;
        mid_run_reset;

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

// File: source/gpio_readback_top.sv
`timescale 1ns/1ps

// GPIO configuration readback path
// Host writes an address, reads the answer on GPIO A and B one cycle later
module gpio_readback_top
    import readback_pkg::*;
#(
    parameter int unsigned ticks_per_second = default_ticks_per_second
)(
    input  logic         aclk,
    input  logic         reset,
    input  logic [31:0]  config_addr, // GPIO output channel
    input  rb_monitors_t monitors,
    output logic [31:0]  gpio_a,      // GPIO input channel A
    output logic [31:0]  gpio_b,      // GPIO input channel B
    output logic [31:0]  clock_sec,
    output logic [31:0]  clock_ticks
);

    logic [31:0] state_count; // Tracker to mux
    logic        startup;

    ////////////////////////////////////////////////////////////
    // Time base
    ////////////////////////////////////////////////////////////
    uptime_clock #(
        .ticks_per_second(ticks_per_second)
    ) u_uptime_clock (
        .aclk   (aclk),
        .reset  (reset),
        .seconds(clock_sec),  // Also feeds the mux
        .ticks  (clock_ticks)
    );

    // Cold start state
    system_state_tracker u_system_state_tracker (
        .aclk       (aclk),
        .reset      (reset),
        .config_addr(config_addr),
        .state_count(state_count),
        .startup    (startup)
    );

    ////////////////////////////////////////////////////////////
    // Readback decode and output words
    ////////////////////////////////////////////////////////////
    readback_mux u_readback_mux (
        .aclk       (aclk),
        .reset      (reset),
        .config_addr(config_addr),
        .monitors   (monitors),
        .seconds    (clock_sec),
        .ticks      (clock_ticks),
        .state_count(state_count),
        .startup    (startup),
        .gpio_a     (gpio_a),
        .gpio_b     (gpio_b)
    );

endmodule

// File: source/readback_mux.sv
`timescale 1ns/1ps

// Address decoder for the GPIO readback pair
// One cycle from address to registered A/B words
module readback_mux
    import readback_pkg::*;
(
    input  logic         aclk,
    input  logic         reset,
    input  logic [31:0]  config_addr,
    input  rb_monitors_t monitors,    // Live values from the controller
    input  logic [31:0]  seconds,
    input  logic [31:0]  ticks,
    input  logic [31:0]  state_count,
    input  logic         startup,
    output logic [31:0]  gpio_a,
    output logic [31:0]  gpio_b
);

    rb_pair_t next_pair; // Word pair loaded at next edge

    ////////////////////////////////////////////////////////////
    // Address decode
    ////////////////////////////////////////////////////////////
    always_comb
    begin
        case (config_addr)
            rb_addr_z:        next_pair = monitors.z;
            rb_addr_bias:     next_pair = monitors.bias;
            rb_addr_gvp_bias: next_pair = monitors.gvp_bias;
            rb_addr_pmd_da56: next_pair = monitors.pmd_da56;
            rb_addr_z_servo:  next_pair = monitors.z_servo;
            rb_addr_amc_fmc:  next_pair = monitors.amc_fmc;
            rb_addr_srcs_mux: next_pair = monitors.mux_sel; // Source and input together
            rb_addr_ad463x:   next_pair = monitors.ad463x;
            rb_addr_spare:    next_pair = monitors.spare;

            rb_addr_in_mux:
            begin
                next_pair.a = monitors.mux_sel.b; // Input selection alone
                next_pair.b = '0;
            end

            rb_addr_uptime:
            begin
                next_pair.a = seconds;
                next_pair.b = ticks; // Sub-second remainder
            end

            // Constant in A, B trails A by one cycle
            rb_addr_timing_test:
            begin
                next_pair.a = timing_test_word;
                next_pair.b = gpio_a;
            end

            rb_addr_timing_reset:
            begin
                next_pair = '0;
            end

            rb_addr_version:
            begin
                next_pair.a = fw_version;
                next_pair.b = fw_build_date;
            end

            rb_addr_system_state:
            begin
                next_pair.a = state_count; // Value before any increment
                next_pair.b = {31'd0, startup};
            end

            // Free running test pattern for unmapped addresses
            default:
            begin
                next_pair.a = gpio_a + 32'd1;
                next_pair.b = gpio_a + pattern_offset;
            end
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Output registers
    ////////////////////////////////////////////////////////////
    always_ff @(posedge aclk)
    begin
        if (reset)
        begin
            gpio_a <= '0;
            gpio_b <= '0;
        end
        else
        begin
            gpio_a <= next_pair.a; // Updated every cycle
            gpio_b <= next_pair.b;
        end
    end

endmodule

// File: source/system_state_tracker.sv
`timescale 1ns/1ps

// Cold start detection for host software
// startup stays set until the firmware version is read once
// state_count steps once per rearmed system state read
module system_state_tracker
    import readback_pkg::*;
(
    input  logic        aclk,
    input  logic        reset,
    input  logic [31:0] config_addr, // Level from GPIO output
    output logic [31:0] state_count,
    output logic        startup
);

    logic armed;    // Set by any unmapped address
    logic unmapped;

    assign unmapped = !rb_addr_mapped(config_addr);

    ////////////////////////////////////////////////////////////
    // Startup flag and rearmed state counter
    ////////////////////////////////////////////////////////////
    always_ff @(posedge aclk)
    begin
        if (reset)
        begin
            startup     <= 1'b1; // Fresh FPGA
            state_count <= '0;
            armed       <= 1'b0;
        end
        else
        begin
            if (config_addr == rb_addr_version)
                startup <= 1'b0; // Cleared for good until next reset

            if (unmapped)
            begin
                armed <= 1'b1;
            end
            else if (config_addr == rb_addr_system_state && armed)
            begin
                state_count <= state_count + 32'd1; // One step per arming
                armed       <= 1'b0;
            end
        end
    end

    // Only reset may bring back the cold start flag
    assert property (@(posedge aclk) $rose(startup) |-> $past(reset))
        else $error("system_state_tracker: startup rose outside reset");

    // Counter never jumps by more than one step
    assert property (@(posedge aclk) disable iff (reset)
        !$past(reset) |-> (state_count == $past(state_count)) ||
                          (state_count == $past(state_count) + 32'd1))
        else $error("system_state_tracker: state_count jumped to %0d", state_count);

endmodule

// File: source/uptime_clock.sv
`timescale 1ns/1ps

// Monotonic FPGA time base
// Wraps after roughly 136 years at one count per second
module uptime_clock
    import readback_pkg::*;
#(
    parameter int unsigned ticks_per_second = default_ticks_per_second
)(
    input  logic        aclk,
    input  logic        reset,
    output logic [31:0] seconds, // Whole seconds since reset
    output logic [31:0] ticks    // Remaining ticks in current second
);

    localparam logic [31:0] tick_reload = 32'(ticks_per_second - 1);

    ////////////////////////////////////////////////////////////
    // Down counting sub-second ticks and seconds carry
    ////////////////////////////////////////////////////////////
    always_ff @(posedge aclk)
    begin
        if (reset)
        begin
            seconds <= '0;
            ticks   <= '0; // Zero forces reload on first cycle
        end
        else if (ticks == '0)
        begin
            ticks   <= tick_reload;
            seconds <= seconds + 32'd1; // Carry into seconds
        end
        else
        begin
            ticks <= ticks - 32'd1;
        end
    end

    // Tick count stays inside one second at all times
    assert property (@(posedge aclk) disable iff (reset) ticks <= tick_reload)
        else $error("uptime_clock: ticks %0d beyond reload %0d", ticks, tick_reload);

endmodule

// File: source/readback_pkg.sv
package readback_pkg;

    ////////////////////////////////////////////////////////////
    // Readback addresses written by the host to the GPIO
    ////////////////////////////////////////////////////////////
    localparam logic [31:0] rb_addr_z            = 32'd100001; // Z monitor pair
    localparam logic [31:0] rb_addr_bias         = 32'd100002; // Bias sum and set value
    localparam logic [31:0] rb_addr_gvp_bias     = 32'd100003; // GVP bias and modifiers
    localparam logic [31:0] rb_addr_pmd_da56     = 32'd100004; // PMD DAC 5 and 6
    localparam logic [31:0] rb_addr_z_servo      = 32'd100005;
    localparam logic [31:0] rb_addr_amc_fmc      = 32'd100006;
    localparam logic [31:0] rb_addr_srcs_mux     = 32'd100010; // Source and input selections
    localparam logic [31:0] rb_addr_in_mux       = 32'd100011; // Input selection only
    localparam logic [31:0] rb_addr_ad463x       = 32'd100100; // ADC channels 1 and 2
    localparam logic [31:0] rb_addr_spare        = 32'd100999;
    localparam logic [31:0] rb_addr_uptime       = 32'd101900;
    localparam logic [31:0] rb_addr_timing_test  = 32'd101999;
    localparam logic [31:0] rb_addr_timing_reset = 32'd102000;
    localparam logic [31:0] rb_addr_version      = 32'd199997; // Also ends cold start
    localparam logic [31:0] rb_addr_system_state = 32'd199999;

    // Firmware identification
    localparam logic [31:0] fw_version    = 32'hEC01_0099;
    localparam logic [31:0] fw_build_date = 32'h0001_0000; // Build stamp, set at release

    localparam logic [31:0] timing_test_word = 32'd125_000_000; // One second of 8 ns ticks
    localparam int unsigned default_ticks_per_second = 125_000_000; // 125 MHz aclk
    localparam logic [31:0] pattern_offset = 32'd13; // Word B lead over old word A

    ////////////////////////////////////////////////////////////
    // Readback word pair and live monitor bundle
    ////////////////////////////////////////////////////////////
    typedef struct packed {
        logic [31:0] a; // Goes to GPIO A
        logic [31:0] b; // Goes to GPIO B
    } rb_pair_t;

    typedef struct packed {
        rb_pair_t z;        // Z GVP and Z slope
        rb_pair_t bias;     // Bias sum and U0 bias
        rb_pair_t gvp_bias; // GVP bias and bias modifiers
        rb_pair_t pmd_da56;
        rb_pair_t z_servo;
        rb_pair_t amc_fmc;
        rb_pair_t mux_sel;  // a is source select, b is input select
        rb_pair_t ad463x;
        rb_pair_t spare;
    } rb_monitors_t;

    // True for every address with a defined readback
    function automatic logic rb_addr_mapped(input logic [31:0] addr);
        case (addr)
            rb_addr_z, rb_addr_bias, rb_addr_gvp_bias, rb_addr_pmd_da56,
            rb_addr_z_servo, rb_addr_amc_fmc, rb_addr_srcs_mux, rb_addr_in_mux,
            rb_addr_ad463x, rb_addr_spare, rb_addr_uptime, rb_addr_timing_test,
            rb_addr_timing_reset, rb_addr_version, rb_addr_system_state:
                return 1'b1;
            default:
                return 1'b0;
        endcase
    endfunction

endpackage
